//--- src/rv32i_macros.svh
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// Datapath and register index widths
`define XLEN        32
`define REG_ADDR_W  5

// Instruction field widths
`define OPCODE_W    7   // insn[6:0]
`define FUNCT3_W    3   // insn[14:12]

// Byte distance between instruction words
`define PC_STEP     4

`endif

//--- src/rv32i_pkg.sv
`default_nettype none

`include "rv32i_macros.svh"

package rv32i_pkg;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Kept major opcodes, anything else runs as a no-op
    typedef enum logic [`OPCODE_W-1:0] {
        OP_LOAD  = 7'b0000011,
        OP_IMM   = 7'b0010011,
        OP_STORE = 7'b0100011,
        OP_REG   = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_SLL  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_XOR  = 4'b0110,
        ALU_OR   = 4'b0111,
        ALU_AND  = 4'b1000,
        ALU_SRA  = 4'b1001
    } alu_op_e;

    ////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`XLEN-1:0]       rs1_val;
        logic [`XLEN-1:0]       rs2_val;
        logic [`XLEN-1:0]       imm;        // I or S form, sign extended
        logic [`FUNCT3_W-1:0]   funct3;
        logic                   funct7_b30; // SUB / SRA select
        logic                   alu_src;    // Immediate as operand b
        logic                   is_reg_op;
        logic                   mem_read;
        logic                   mem_write;
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic [`XLEN-1:0]       alu_result; // Also the memory address
        logic [`XLEN-1:0]       store_data;
        logic [`FUNCT3_W-1:0]   funct3;     // Load width and sign
        logic                   mem_read;
        logic                   mem_write;
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    // Load or ALU value already picked
    typedef struct packed {
        logic [`XLEN-1:0]       wb_data;
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- src/fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module fetch_pc (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,      // Hazard hold from decode
    input  logic [`XLEN-1:0] imem_insn,
    output logic [`XLEN-1:0] imem_addr,
    output logic [`XLEN-1:0] if_pc,
    output logic [`XLEN-1:0] if_insn
);

    logic [`XLEN-1:0] pc;

    assign imem_addr = pc;  // Memory answers in the same cycle

    // PC and fetch/decode register freeze under stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            if_pc   <= '0;
            if_insn <= '0;  // Opcode 0 decodes as a no-op
        end else if (!stall) begin
            pc      <= pc + `XLEN'(`PC_STEP);
            if_pc   <= pc;
            if_insn <= imem_insn;
        end
    end

    // A hazard drains within two stall cycles
    a_stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        stall && $past(stall) |=> !stall);

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    output logic [`XLEN-1:0]       rs1_val,
    output logic [`XLEN-1:0]       rs2_val,
    input  logic                   wb_en,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data
);

    logic [`XLEN-1:0] regs [2**`REG_ADDR_W];

    // Falling edge write, so decode reads the new value this cycle
    always_ff @(negedge clk) begin
        if (wb_en && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // x0 hard-wired, never read from the array
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    // Writeback index arrives from the memory stage register
    a_wb_rd_known: assert property (@(negedge clk) disable iff (!rst_n)
        wb_en |-> !$isunknown(wb_rd));

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`XLEN-1:0]       if_insn,
    input  logic [`REG_ADDR_W-1:0] ex_rd,         // rd now in memory stage
    input  logic                   ex_reg_write,
    input  logic                   wb_en,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data,
    output logic                   stall,
    output rv32i_pkg::id_ex_t      id_ex
);

    rv32i_pkg::opcode_e     opcode;
    rv32i_pkg::id_ex_t      id_next;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       rs1_val;
    logic [`XLEN-1:0]       rs2_val;
    logic                   use_rs1;
    logic                   use_rs2;

    assign opcode = rv32i_pkg::opcode_e'(if_insn[6:0]);
    assign rs1    = if_insn[19:15];
    assign rs2    = if_insn[24:20];

    reg_file reg_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    ////////////////////////////////////////////////////////////
    // Control and immediates
    ////////////////////////////////////////////////////////////

    always_comb begin
        id_next            = '0;   // Unknown opcode stays a no-op
        id_next.rs1_val    = rs1_val;
        id_next.rs2_val    = rs2_val;
        id_next.funct3     = if_insn[14:12];
        id_next.funct7_b30 = if_insn[30];
        id_next.rd         = if_insn[11:7];
        use_rs1            = 1'b0;
        use_rs2            = 1'b0;
        case (opcode)
            rv32i_pkg::OP_IMM: begin
                id_next.imm       = {{(`XLEN-12){if_insn[31]}}, if_insn[31:20]};
                id_next.alu_src   = 1'b1;
                id_next.reg_write = 1'b1;
                use_rs1           = 1'b1;
            end
            rv32i_pkg::OP_LOAD: begin
                id_next.imm       = {{(`XLEN-12){if_insn[31]}}, if_insn[31:20]};
                id_next.alu_src   = 1'b1;
                id_next.mem_read  = 1'b1;
                id_next.reg_write = 1'b1;
                use_rs1           = 1'b1;
            end
            rv32i_pkg::OP_STORE: begin
                // S form splits the offset around rd
                id_next.imm       = {{(`XLEN-12){if_insn[31]}}, if_insn[31:25], if_insn[11:7]};
                id_next.alu_src   = 1'b1;
                id_next.mem_write = (if_insn[14:12] == 3'b010);  // SW only
                use_rs1           = 1'b1;
                use_rs2           = 1'b1;
            end
            rv32i_pkg::OP_REG: begin
                id_next.is_reg_op = 1'b1;
                id_next.reg_write = 1'b1;
                use_rs1           = 1'b1;
                use_rs2           = 1'b1;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // RAW interlock
    ////////////////////////////////////////////////////////////

    // Pending writer in execute or memory, writeback is covered by the negedge write
    function automatic logic pending(input logic [`REG_ADDR_W-1:0] rs);
        return (rs != '0) && ((id_ex.reg_write && (id_ex.rd == rs)) ||
                              (ex_reg_write && (ex_rd == rs)));
    endfunction

    // I-type bits in the rs2 slot are immediate, not a source
    assign stall = (use_rs1 && pending(rs1)) || (use_rs2 && pending(rs2));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (stall) begin
            id_ex <= '0;       // Bubble, no register or memory write
        end else begin
            id_ex <= id_next;
        end
    end

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module alu (
    input  rv32i_pkg::alu_op_e op,
    input  logic [`XLEN-1:0]   a,
    input  logic [`XLEN-1:0]   b,
    output logic [`XLEN-1:0]   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Upper bits of b ignored for shifts

    always_comb begin
        case (op)
            rv32i_pkg::ALU_ADD:  result = a + b;
            rv32i_pkg::ALU_SUB:  result = a - b;
            rv32i_pkg::ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            rv32i_pkg::ALU_SLTU: begin
                result = {{(`XLEN-1){1'b0}}, (a < b)};
            end
            rv32i_pkg::ALU_SLL:  result = a << shamt;
            rv32i_pkg::ALU_SRL:  result = a >> shamt;
            rv32i_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);  // Sign fill
            rv32i_pkg::ALU_XOR:  result = a ^ b;
            rv32i_pkg::ALU_OR:   result = a | b;
            rv32i_pkg::ALU_AND:  result = a & b;
            default:             result = '0;  // Unused encodings
        endcase
    end

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module execute_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  rv32i_pkg::id_ex_t  id_ex,
    output rv32i_pkg::ex_mem_t ex_mem
);

    rv32i_pkg::alu_op_e alu_op;
    logic [`XLEN-1:0]   op_b;
    logic [`XLEN-1:0]   alu_result;

    // funct3 / bit 30 to ALU operation
    always_comb begin
        if (id_ex.mem_read || id_ex.mem_write) begin
            alu_op = rv32i_pkg::ALU_ADD;   // Address is rs1 + offset
        end else begin
            case (id_ex.funct3)
                3'b000: begin
                    // ADDI with a negative offset also has bit 30 set
                    alu_op = (id_ex.is_reg_op && id_ex.funct7_b30) ? rv32i_pkg::ALU_SUB
                                                                     : rv32i_pkg::ALU_ADD;
                end
                3'b001:  alu_op = rv32i_pkg::ALU_SLL;
                3'b010:  alu_op = rv32i_pkg::ALU_SLT;
                3'b011:  alu_op = rv32i_pkg::ALU_SLTU;
                3'b100:  alu_op = rv32i_pkg::ALU_XOR;
                3'b101:  alu_op = id_ex.funct7_b30 ? rv32i_pkg::ALU_SRA   // SRA and SRAI
                                                   : rv32i_pkg::ALU_SRL;
                3'b110:  alu_op = rv32i_pkg::ALU_OR;
                default: alu_op = rv32i_pkg::ALU_AND;
            endcase
        end
    end

    assign op_b = id_ex.alu_src ? id_ex.imm : id_ex.rs2_val;

    alu alu_inst (
        .op     (alu_op),
        .a      (id_ex.rs1_val),
        .b      (op_b),
        .result (alu_result)
    );

    ////////////////////////////////////////////////////////////
    // Execute/memory register, never held
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= id_ex.rs2_val;    // SW data, not the immediate
            ex_mem.funct3     <= id_ex.funct3;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.rd         <= id_ex.rd;
        end
    end

endmodule

`default_nettype wire

//--- src/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv32i_pkg::ex_mem_t     ex_mem,
    output logic [`XLEN-1:0]       dmem_addr,
    output logic [`XLEN-1:0]       dmem_wdata,
    output logic                   dmem_wen,
    input  logic [`XLEN-1:0]       dmem_rdata,
    output logic                   wb_en,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);

    rv32i_pkg::mem_wb_t mem_wb;
    logic [`XLEN-1:0]   lane;       // Addressed byte or half at bit 0
    logic [`XLEN-1:0]   load_val;

    // Data memory, combinational answer
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_wen   = ex_mem.mem_write;

    assign lane = dmem_rdata >> {ex_mem.alu_result[1:0], 3'b000};

    // Width and sign from funct3
    always_comb begin
        case (ex_mem.funct3)
            3'b000:  load_val = {{(`XLEN-8){lane[7]}}, lane[7:0]};     // LB
            3'b001:  load_val = {{(`XLEN-16){lane[15]}}, lane[15:0]};  // LH
            3'b100:  load_val = {{(`XLEN-8){1'b0}}, lane[7:0]};        // LBU
            3'b101:  load_val = {{(`XLEN-16){1'b0}}, lane[15:0]};      // LHU
            default: load_val = dmem_rdata;                            // LW
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.wb_data   <= ex_mem.mem_read ? load_val : ex_mem.alu_result;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.rd        <= ex_mem.rd;
        end
    end

    // Writeback to the register file inside decode
    assign wb_en   = mem_wb.reg_write;
    assign wb_rd   = mem_wb.rd;
    assign wb_data = mem_wb.wb_data;

    // Decode never flags both, bubbles clear both
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(ex_mem.mem_read && ex_mem.mem_write));

endmodule

`default_nettype wire

//--- src/rv32i_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module rv32i_core (
    input  logic             clk,
    input  logic             rst_n,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [`XLEN-1:0] imem_insn,
    output logic [`XLEN-1:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    output logic             dmem_wen,
    input  logic [`XLEN-1:0] dmem_rdata
);

    logic                   stall;
    logic [`XLEN-1:0]       if_insn;
    rv32i_pkg::id_ex_t      id_ex;
    rv32i_pkg::ex_mem_t     ex_mem;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;

    ////////////////////////////////////////////////////////////
    // IF -> ID -> EX -> MEM -> WB
    ////////////////////////////////////////////////////////////

    fetch_pc fetch_pc_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .imem_insn (imem_insn),
        .imem_addr (imem_addr),
        .if_pc     (),           // No branches, pc not needed downstream
        .if_insn   (if_insn)
    );

    decode_stage decode_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .if_insn      (if_insn),
        .ex_rd        (ex_mem.rd),          // Second hazard source
        .ex_reg_write (ex_mem.reg_write),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .stall        (stall),
        .id_ex        (id_ex)
    );

    execute_stage execute_stage_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .id_ex  (id_ex),
        .ex_mem (ex_mem)
    );

    mem_stage mem_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wen   (dmem_wen),
        .dmem_rdata (dmem_rdata),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

//--- dv/tb_rv32i_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_core;

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 4;
    localparam int          DRIVE_DELAY  = 1;             // ns after the rising edge
    localparam int          IMEM_WORDS   = 512;
    localparam int          DMEM_WORDS   = 256;
    localparam int          DATA_INDEX   = 32;            // Word index of byte 0x80
    localparam logic [31:0] NOP          = 32'h0000_0013; // ADDI x0, x0, 0

    // RV32I base opcodes
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_REG   = 7'b0110011;

    // Words at 0x80, 0x84, 0x88, 0x8C
    localparam logic [31:0] PRELOAD [4] = '{32'h8000_8081, 32'h7F7F_0102,
                                            32'h1234_5678, 32'hCAFE_F00D};

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_insn;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_wen;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] prog [$];                 // Program table
    logic [31:0] exp_addr [$];             // Expected SW address per store
    logic [31:0] exp_data [$];
    logic [31:0] store_addr  = 32'h100;    // Next result slot
    int          stores_seen = 0;
    int          n_expected  = 0;
    int          cycles      = 0;
    int          cycle_limit = 0;

    rv32i_core rv32i_core_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_insn  (imem_insn),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wen   (dmem_wen),
        .dmem_rdata (dmem_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Hand assembly
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] itype(input logic [6:0] opc, input logic [2:0] f3,
                                          input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    // b30 picks SUB / SRA
    function automatic logic [31:0] rtype(input logic b30, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {1'b0, b30, 5'b00000, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_REG};
    endfunction

    function automatic logic [31:0] stype(input int rs2, input int rs1, input int imm);
        logic [11:0] off;
        off = 12'(imm);
        return {off[11:5], 5'(rs2), 5'(rs1), 3'b010, off[4:0], OPC_STORE};  // SW
    endfunction

    task automatic append(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // SW rs2 to the next slot and record what must land there
    task automatic store_and_expect(input int rs2, input logic [31:0] value);
        prog.push_back(stype(rs2, 0, int'(store_addr)));
        exp_addr.push_back(store_addr);
        exp_data.push_back(value);
        store_addr = store_addr + 32'd4;
    endtask

    ////////////////////////////////////////////////////////////
    // Program and expected stores
    ////////////////////////////////////////////////////////////

    task automatic build_program();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r7;
        logic [31:0] r9;
        logic [31:0] r11;
        logic [31:0] r22;
        r1  = 32'(-20);
        r2  = 32'($signed(r1) < 5);
        r7  = r2 | 32'h555;
        r9  = r7 << 20;
        r11 = 32'd3;
        r22 = 32'd100 + 32'd7;
        // Each SW of the immediate group leans on the line above
        append(itype(OPC_IMM, 3'b000, 1, 0, -20));             // ADDI negative
        store_and_expect(1, r1);
        append(itype(OPC_IMM, 3'b010, 2, 1, 5));               // SLTI
        store_and_expect(2, r2);
        append(itype(OPC_IMM, 3'b011, 3, 1, 5));               // SLTIU
        store_and_expect(3, 32'(r1 < 32'd5));
        append(itype(OPC_IMM, 3'b101, 4, 1, 'h402));           // SRAI by 2
        store_and_expect(4, 32'($signed(r1) >>> 2));
        append(itype(OPC_IMM, 3'b101, 5, 1, 2));               // SRLI by 2
        store_and_expect(5, r1 >> 2);
        append(itype(OPC_IMM, 3'b100, 6, 1, 'h0FF));           // XORI
        store_and_expect(6, r1 ^ 32'h0FF);
        append(itype(OPC_IMM, 3'b110, 7, 2, 'h555));           // ORI
        store_and_expect(7, r7);
        append(itype(OPC_IMM, 3'b111, 8, 1, 'h7F0));           // ANDI
        store_and_expect(8, r1 & 32'h7F0);
        append(itype(OPC_IMM, 3'b001, 9, 7, 20));              // SLLI
        store_and_expect(9, r9);
        append(itype(OPC_IMM, 3'b000, 11, 0, 3));              // Shift amount
        // Register-register group
        append(rtype(1'b0, 3'b000, 12, 9, 7));
        store_and_expect(12, r9 + r7);
        append(rtype(1'b1, 3'b000, 13, 7, 9));                 // SUB
        store_and_expect(13, r7 - r9);
        append(rtype(1'b0, 3'b001, 14, 7, 11));
        store_and_expect(14, r7 << r11[4:0]);
        append(rtype(1'b0, 3'b010, 15, 1, 11));
        store_and_expect(15, 32'($signed(r1) < $signed(r11)));
        append(rtype(1'b0, 3'b011, 16, 1, 11));
        store_and_expect(16, 32'(r1 < r11));
        append(rtype(1'b0, 3'b100, 17, 9, 1));
        store_and_expect(17, r9 ^ r1);
        append(rtype(1'b0, 3'b101, 18, 1, 11));
        store_and_expect(18, r1 >> r11[4:0]);
        append(rtype(1'b1, 3'b101, 19, 1, 11));                // SRA
        store_and_expect(19, 32'($signed(r1) >>> r11[4:0]));
        append(rtype(1'b0, 3'b110, 20, 1, 7));
        store_and_expect(20, r1 | r7);
        append(rtype(1'b0, 3'b111, 21, 1, 7));
        store_and_expect(21, r1 & r7);
        // Dependent chain with no spacing
        append(itype(OPC_IMM, 3'b000, 22, 0, 100));
        append(itype(OPC_IMM, 3'b000, 22, 22, 7));
        append(rtype(1'b0, 3'b000, 23, 22, 22));
        append(rtype(1'b1, 3'b000, 24, 23, 22));
        store_and_expect(24, (r22 + r22) - r22);
        store_and_expect(23, r22 + r22);
        // Loads from the preloaded words
        append(itype(OPC_LOAD, 3'b000, 25, 0, 'h80));          // LB
        store_and_expect(25, {{24{PRELOAD[0][7]}}, PRELOAD[0][7:0]});
        append(itype(OPC_LOAD, 3'b100, 26, 0, 'h80));          // LBU
        store_and_expect(26, {24'h0, PRELOAD[0][7:0]});
        append(itype(OPC_LOAD, 3'b001, 27, 0, 'h80));          // LH
        store_and_expect(27, {{16{PRELOAD[0][15]}}, PRELOAD[0][15:0]});
        append(itype(OPC_LOAD, 3'b101, 28, 0, 'h80));          // LHU
        store_and_expect(28, {16'h0, PRELOAD[0][15:0]});
        append(itype(OPC_LOAD, 3'b010, 29, 0, 'h80));          // LW
        store_and_expect(29, PRELOAD[0]);
        append(itype(OPC_LOAD, 3'b000, 30, 0, 'h83));          // LB top byte
        store_and_expect(30, {{24{PRELOAD[0][31]}}, PRELOAD[0][31:24]});
        append(itype(OPC_LOAD, 3'b001, 31, 0, 'h86));          // LH upper half
        store_and_expect(31, {{16{PRELOAD[1][31]}}, PRELOAD[1][31:16]});
        append(itype(OPC_LOAD, 3'b010, 25, 0, 'h8C));          // Load then use
        append(itype(OPC_IMM, 3'b000, 25, 25, 1));
        store_and_expect(25, PRELOAD[3] + 32'd1);
        // x0 stays zero
        append(itype(OPC_IMM, 3'b000, 0, 0, 99));
        store_and_expect(0, 32'd0);
        append(rtype(1'b0, 3'b000, 0, 1, 7));
        store_and_expect(0, 32'd0);
        append(itype(OPC_IMM, 3'b000, 10, 0, 5));
        store_and_expect(10, 32'd5);
    endtask

    task automatic load_memories();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : NOP;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = {16'hD0D0, 16'(i * 4)};   // Low half is the byte address
        end
        for (int k = 0; k < 4; k++) begin
            dmem[DATA_INDEX + k] = PRELOAD[k];
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if ((addr >> 2) < IMEM_WORDS) begin
            return imem[addr[10:2]];
        end
        return NOP;   // Past the array
    endfunction

    ////////////////////////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////////////////////////

    // Answers settle a little after the edge
    always @(posedge clk) begin
        #DRIVE_DELAY;
        imem_insn  = fetch_word(imem_addr);
        dmem_rdata = dmem[dmem_addr[9:2]];
    end

    always @(posedge clk) begin
        if (rst_n && dmem_wen) begin
            dmem[dmem_addr[9:2]] = dmem_wdata;
        end
    end

    // Store monitor samples mid-cycle
    always @(negedge clk) begin
        if (rst_n && dmem_wen) begin
            assert (stores_seen < n_expected) else begin
                $display("Unexpected store to 0x%08h after all expected stores", dmem_addr);
                $display("TEST FAIL");
                $fatal(1, "Extra store");
            end
            assert (dmem_addr == exp_addr[stores_seen] &&
                    dmem_wdata == exp_data[stores_seen]) else begin
                $display("[ERROR] %0t: store %0d wrote 0x%08h to 0x%08h, expected 0x%08h to 0x%08h",
                         $time, stores_seen, dmem_wdata, dmem_addr,
                         exp_data[stores_seen], exp_addr[stores_seen]);
                $display("TEST FAIL");
                $fatal(1, "Store mismatch");
            end
            stores_seen = stores_seen + 1;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles = cycles + 1;
            assert (cycles < cycle_limit) else begin
                $display("Timeout after %0d cycles with %0d of %0d stores seen",
                         cycles, stores_seen, n_expected);
                $display("TEST FAIL");
                $fatal(1, "Timeout");
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        imem_insn  = NOP;
        dmem_rdata = '0;
        build_program();
        load_memories();
        n_expected  = exp_addr.size();
        cycle_limit = 5 * prog.size() + 50;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            assert (!dmem_wen && imem_addr == '0) else begin
                $display("[ERROR] %0t: in reset imem_addr 0x%08h dmem_wen %0b",
                         $time, imem_addr, dmem_wen);
                $display("TEST FAIL");
                $fatal(1, "Reset state");
            end
        end
        rst_n = 1'b1;
        // No store while the pipeline fills
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            assert (!dmem_wen && (i > 0 || imem_addr == '0)) else begin
                $display("[ERROR] %0t: after reset imem_addr 0x%08h dmem_wen %0b",
                         $time, imem_addr, dmem_wen);
                $display("TEST FAIL");
                $fatal(1, "Post-reset state");
            end
        end
        wait (stores_seen == n_expected);
        repeat (8) @(posedge clk);   // Room for a stray extra store
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- rv32i_core.f
+incdir+src
src/rv32i_pkg.sv
src/fetch_pc.sv
src/reg_file.sv
src/decode_stage.sv
src/alu.sv
src/execute_stage.sv
src/mem_stage.sv
src/rv32i_core.sv
dv/tb_rv32i_core.sv

//--- run.sh
#!/bin/sh
# Build and run the rv32i_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_rv32i_core \
    -f rv32i_core.f \
    -o sim_rv32i_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_rv32i_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
